/* hdl/devId_consts.svh */
`ifndef DEVID_CONSTS_SVH
`define DEVID_CONSTS_SVH

// SPI link timing
`define SPI_CLKS_PER_HALF_BIT 4      // System clocks per SCLK half period
`define SPI_CS_INACTIVE_CLKS  2      // Min idle cycles with CS high between frames
`define SPI_MODE_SEL          0      // CPOL = 0, CPHA = 0

// ID read frame contents
`define DEVID_FRAME_BYTES     3      // Command, address, dummy
`define DEVID_READ_CMD        8'h0B
`define DEVID_REG_ADDR        8'h00
`define DEVID_EXPECTED        8'hAD  // Value the part must return

`endif

/* hdl/spiPkg.sv */
`default_nettype none

// Types shared by everything that touches the SPI wires
package spiPkg;

  // One data byte on MOSI or MISO
  typedef logic [7:0] spiByte_t;

  // Bit position inside a byte, MSB is shifted first
  typedef logic [2:0] spiBitIdx_t;

  // Mode number, bit 1 is CPOL and bit 0 is CPHA
  typedef logic [1:0] spiMode_t;

endpackage : spiPkg

`default_nettype wire

/* hdl/devIdPkg.sv */
`default_nettype none

// Types for the device-ID read sequence
package devIdPkg;

  ////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////
  typedef enum logic [2:0] {
    SeqIdle      = 3'd0,  // Waiting for start
    SeqSend      = 3'd1,  // TX_DV pulse out
    SeqWaitReady = 3'd2,  // Waiting for framer ready
    SeqWaitFrame = 3'd3,  // All bytes issued, wait for CS to rise
    SeqDone      = 3'd4   // Publish result
  } seqState_t;

  ////////////////////////////////
  // Frame byte count
  ////////////////////////////////
  // Holds 0 to 3, enough for a three byte frame plus the "all sent" value
  typedef logic [1:0] byteCnt_t;

endpackage : devIdPkg

`default_nettype wire

/* hdl/spiByteMaster.sv */
`default_nettype none

module spiByteMaster
  #(parameter spiPkg::spiMode_t SpiMode        = 2'd0,
    parameter int               ClksPerHalfBit = 2)   // Must be 2 or more
  (
    input  wire logic             i_Clk,
    input  wire logic             i_Rst_L,
    // TX side
    input  wire spiPkg::spiByte_t i_TX_Byte,   // Byte for MOSI
    input  wire logic             i_TX_DV,     // One cycle strobe with i_TX_Byte
    output logic                  o_TX_Ready,  // High when a new byte can start
    // RX side
    output logic                  o_RX_DV,     // One cycle strobe with o_RX_Byte
    output spiPkg::spiByte_t      o_RX_Byte,
    // SPI pins
    output logic                  o_SPI_Clk,
    input  wire logic             i_SPI_MISO,
    output logic                  o_SPI_MOSI
  );

  import spiPkg::*;

  localparam logic Cpol = SpiMode[1];                  // SCLK idle level
  localparam logic Cpha = SpiMode[0];                  // 1 = data changes on leading edge
  localparam int   CntW = $clog2(ClksPerHalfBit * 2);

  logic [CntW-1:0] rClkCnt;     // Position inside one SCLK period
  logic [4:0]      rEdgesLeft;  // 16 edges per byte
  logic            rSpiClk;     // Internal SCLK, one cycle ahead of the pin
  logic            rLeadEdge;
  logic            rTrailEdge;
  logic            rTxDv;       // i_TX_DV delayed one cycle
  spiByte_t        rTxByte;
  spiBitIdx_t      rTxBitIdx;
  spiBitIdx_t      rRxBitIdx;
  logic            wDriveStb;   // Edge on which MOSI moves
  logic            wSampleStb;  // Edge on which MISO is taken

  assign wDriveStb  = (rLeadEdge & Cpha) | (rTrailEdge & ~Cpha);
  assign wSampleStb = ~o_TX_Ready & ((rLeadEdge & ~Cpha) | (rTrailEdge & Cpha));

  //////////////////////////////
  // SCLK edge generation
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_TX_Ready <= 1'b1;
      rEdgesLeft <= '0;
      rLeadEdge  <= 1'b0;
      rTrailEdge <= 1'b0;
      rSpiClk    <= Cpol;   // Park at idle polarity
      rClkCnt    <= '0;
    end
    else
    begin
      rLeadEdge  <= 1'b0;   // Strobes last one cycle
      rTrailEdge <= 1'b0;

      if (i_TX_DV)
      begin
        o_TX_Ready <= 1'b0;
        rEdgesLeft <= 5'd16;
      end
      else if (rEdgesLeft != '0)
      begin
        o_TX_Ready <= 1'b0;
        if (rClkCnt == CntW'(ClksPerHalfBit * 2 - 1))
        begin
          rEdgesLeft <= rEdgesLeft - 1'b1;
          rTrailEdge <= 1'b1;             // Back to idle level
          rClkCnt    <= '0;
          rSpiClk    <= ~rSpiClk;
        end
        else if (rClkCnt == CntW'(ClksPerHalfBit - 1))
        begin
          rEdgesLeft <= rEdgesLeft - 1'b1;
          rLeadEdge  <= 1'b1;             // Away from idle level
          rClkCnt    <= rClkCnt + 1'b1;
          rSpiClk    <= ~rSpiClk;
        end
        else
          rClkCnt <= rClkCnt + 1'b1;
      end
      else
        o_TX_Ready <= 1'b1;                // Last edge done
    end
  end

  // TX byte held locally so the source may change after the strobe
  always_ff @(posedge i_Clk)
  begin
    if (i_TX_DV)
      rTxByte <= i_TX_Byte;
  end

  //////////////////////////////
  // MOSI shift, MSB first
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      rTxDv      <= 1'b0;
      o_SPI_MOSI <= 1'b0;
      rTxBitIdx  <= '1;
    end
    else
    begin
      rTxDv <= i_TX_DV;
      if (o_TX_Ready)
        rTxBitIdx <= '1;
      else if (rTxDv & ~Cpha)
      begin
        // CPHA 0 needs bit 7 on the line before the first edge
        o_SPI_MOSI <= rTxByte[7];
        rTxBitIdx  <= 3'd6;
      end
      else if (wDriveStb)
      begin
        o_SPI_MOSI <= rTxByte[rTxBitIdx];
        rTxBitIdx  <= rTxBitIdx - 1'b1;
      end
    end
  end

  //////////////////////////////
  // MISO capture
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_RX_DV   <= 1'b0;
      rRxBitIdx <= '1;
    end
    else
    begin
      o_RX_DV <= 1'b0;
      if (o_TX_Ready)
        rRxBitIdx <= '1;
      else if (wSampleStb)
      begin
        rRxBitIdx <= rRxBitIdx - 1'b1;
        if (rRxBitIdx == '0)
          o_RX_DV <= 1'b1;                 // Eighth sample taken
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (wSampleStb)
      o_RX_Byte[rRxBitIdx] <= i_SPI_MISO;
  end

  // Pin delayed one cycle so SCLK lines up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_SPI_Clk <= Cpol;
    else
      o_SPI_Clk <= rSpiClk;
  end

  // A new byte may only start while the previous one is finished
  aDvWhileReady: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_TX_DV |-> o_TX_Ready);

  // Even edge count, so SCLK is back at its idle level between bytes
  aClkIdleWhenReady: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    o_TX_Ready |-> (o_SPI_Clk == Cpol));

endmodule : spiByteMaster

`default_nettype wire

/* hdl/spiCsFrame.sv */
`default_nettype none

module spiCsFrame
  #(parameter int FrameBytes     = 3,
    parameter int CsInactiveClks = 1)
  (
    input  wire logic i_Clk,
    input  wire logic i_Rst_L,
    input  wire logic i_TX_DV,         // Same strobe the byte master sees
    input  wire logic i_Master_Ready,  // Byte master idle
    output logic      o_TX_Ready,      // Ready offered to the sequencer
    output logic      o_Frame_Done,    // One cycle, CS just went high
    output logic      o_SPI_CS_n
  );

  import devIdPkg::*;

  localparam int GapW = $clog2(CsInactiveClks + 1);

  typedef enum logic [1:0] {
    CsIdle,
    CsXfer,
    CsGap
  } csState_t;

  csState_t        rState;
  byteCnt_t        rBytesLeft;  // Bytes still to start in this frame
  logic [GapW-1:0] rGapCnt;

  //////////////////////////////
  // Frame FSM
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      rState       <= CsIdle;
      o_SPI_CS_n   <= 1'b1;
      o_Frame_Done <= 1'b0;
      rBytesLeft   <= '0;
      rGapCnt      <= GapW'(CsInactiveClks);
    end
    else
    begin
      o_Frame_Done <= 1'b0;
      case (rState)
        CsIdle:
        begin
          if (i_TX_DV)                                   // First byte opens the frame
          begin
            rBytesLeft <= byteCnt_t'(FrameBytes - 1);
            o_SPI_CS_n <= 1'b0;
            rState     <= CsXfer;
          end
        end

        CsXfer:
        begin
          if (i_Master_Ready)
          begin
            if (rBytesLeft != '0)
            begin
              if (i_TX_DV)
                rBytesLeft <= rBytesLeft - 1'b1;
            end
            else
            begin
              o_SPI_CS_n   <= 1'b1;                      // Frame over
              o_Frame_Done <= 1'b1;
              rGapCnt      <= GapW'(CsInactiveClks);
              rState       <= CsGap;
            end
          end
        end

        CsGap:
        begin
          // Hold CS high CsInactiveClks + 1 cycles before offering ready
          if (rGapCnt != '0)
            rGapCnt <= rGapCnt - 1'b1;
          else
            rState <= CsIdle;
        end

        default:
        begin
          o_SPI_CS_n <= 1'b1;
          rState     <= CsIdle;
        end
      endcase
    end
  end

  // Ready is dropped in the strobe cycle so one ready gives one byte
  assign o_TX_Ready = ((rState == CsIdle) |
                       ((rState == CsXfer) & i_Master_Ready & (rBytesLeft != '0)))
                      & ~i_TX_DV;

  // Byte master only runs inside an open frame
  aCsLowWhileBusy: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    !i_Master_Ready |-> !o_SPI_CS_n);

endmodule : spiCsFrame

`default_nettype wire

/* hdl/devIdSequencer.sv */
`default_nettype none

`include "devId_consts.svh"

module devIdSequencer
  (
    input  wire logic             i_Clk,
    input  wire logic             i_Rst_L,
    input  wire logic             i_Start,       // Level, sampled in idle
    input  wire logic             i_TX_Ready,    // From the CS framer
    input  wire logic             i_RX_DV,
    input  wire spiPkg::spiByte_t i_RX_Byte,
    input  wire logic             i_Frame_Done,
    output spiPkg::spiByte_t      o_TX_Byte,
    output logic                  o_TX_DV,
    output logic                  o_Busy,
    output logic                  o_Done,        // One cycle per read
    output spiPkg::spiByte_t      o_Id_Byte,
    output logic                  o_Id_Match
  );

  import spiPkg::*;
  import devIdPkg::*;

  localparam byteCnt_t LastIdx = byteCnt_t'(`DEVID_FRAME_BYTES - 1);  // ID arrives here
  localparam byteCnt_t AllSent = byteCnt_t'(`DEVID_FRAME_BYTES);

  seqState_t rState;
  byteCnt_t  rByteIdx;   // Next byte to issue
  byteCnt_t  rRxCnt;     // Bytes received this frame
  spiByte_t  rIdCapt;    // ID as received, published at done
  logic      rIdMatch;
  spiByte_t  wNextByte;

  // Frame contents
  always_comb
  begin
    case (rByteIdx)
      2'd0:    wNextByte = `DEVID_READ_CMD;
      2'd1:    wNextByte = `DEVID_REG_ADDR;
      default: wNextByte = 8'h00;   // Dummy, clocks the ID in
    endcase
  end

  //////////////////////////////
  // Sequencer FSM
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      rState     <= SeqIdle;
      rByteIdx   <= '0;
      o_TX_DV    <= 1'b0;
      o_Done     <= 1'b0;
      o_Id_Byte  <= '0;
      o_Id_Match <= 1'b0;
    end
    else
    begin
      o_TX_DV <= 1'b0;
      o_Done  <= 1'b0;
      case (rState)
        SeqIdle:
        begin
          rByteIdx <= '0;
          if (i_Start)
            rState <= SeqWaitReady;
        end

        SeqWaitReady:
        begin
          if (i_TX_Ready)                    // Byte goes out next cycle
          begin
            o_TX_DV  <= 1'b1;
            rByteIdx <= rByteIdx + 1'b1;
            rState   <= SeqSend;
          end
        end

        SeqSend:
          rState <= (rByteIdx == AllSent) ? SeqWaitFrame : SeqWaitReady;

        SeqWaitFrame:
        begin
          if (i_Frame_Done)
          begin
            o_Done     <= 1'b1;
            o_Id_Byte  <= rIdCapt;
            o_Id_Match <= rIdMatch;
            rState     <= SeqDone;
          end
        end

        SeqDone:
          rState <= SeqIdle;                 // Start still high restarts from here

        default:
          rState <= SeqIdle;
      endcase
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (rState == SeqWaitReady && i_TX_Ready)
      o_TX_Byte <= wNextByte;
  end

  //////////////////////////////
  // RX byte tracking
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      rRxCnt   <= '0;
      rIdMatch <= 1'b0;
    end
    else if (rState == SeqIdle)
      rRxCnt <= '0;
    else if (i_RX_DV)
    begin
      rRxCnt <= rRxCnt + 1'b1;
      if (rRxCnt == LastIdx)
        rIdMatch <= (i_RX_Byte == `DEVID_EXPECTED);  // Compared once per read
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (i_RX_DV && rRxCnt == LastIdx)
      rIdCapt <= i_RX_Byte;
  end

  assign o_Busy = (rState != SeqIdle);

  // CS rises only after every byte of the frame came back
  aDoneAfterAllRx: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    o_Done |-> (rRxCnt == AllSent));

endmodule : devIdSequencer

`default_nettype wire

/* hdl/devIdReader.sv */
`default_nettype none

`include "devId_consts.svh"

module devIdReader
  (
    input  wire logic        i_Clk,
    input  wire logic        i_Rst_L,
    input  wire logic        i_Start,
    // SPI pins
    input  wire logic        i_SPI_MISO,
    output logic             o_SPI_Clk,
    output logic             o_SPI_MOSI,
    output logic             o_SPI_CS_n,
    // Result
    output logic             o_Busy,
    output logic             o_Done,
    output spiPkg::spiByte_t o_Id_Byte,
    output logic             o_Id_Match
  );

  import spiPkg::*;

  spiByte_t wTxByte;
  logic     wTxDv;        // Shared by master and framer
  logic     wTxReady;     // Framer ready to sequencer
  logic     wMasterReady;
  logic     wRxDv;
  spiByte_t wRxByte;
  logic     wFrameDone;

  // Byte order and result
  devIdSequencer devIdSequencer_inst (
    .i_Clk        (i_Clk),
    .i_Rst_L      (i_Rst_L),
    .i_Start      (i_Start),
    .i_TX_Ready   (wTxReady),
    .i_RX_DV      (wRxDv),
    .i_RX_Byte    (wRxByte),
    .i_Frame_Done (wFrameDone),
    .o_TX_Byte    (wTxByte),
    .o_TX_DV      (wTxDv),
    .o_Busy       (o_Busy),
    .o_Done       (o_Done),
    .o_Id_Byte    (o_Id_Byte),
    .o_Id_Match   (o_Id_Match)
  );

  // SCLK, MOSI and MISO
  spiByteMaster #(
    .SpiMode        (`SPI_MODE_SEL),
    .ClksPerHalfBit (`SPI_CLKS_PER_HALF_BIT)
  ) spiByteMaster_inst (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_TX_Byte  (wTxByte),
    .i_TX_DV    (wTxDv),
    .o_TX_Ready (wMasterReady),
    .o_RX_DV    (wRxDv),
    .o_RX_Byte  (wRxByte),
    .o_SPI_Clk  (o_SPI_Clk),
    .i_SPI_MISO (i_SPI_MISO),
    .o_SPI_MOSI (o_SPI_MOSI)
  );

  // Chip select around the whole frame
  spiCsFrame #(
    .FrameBytes     (`DEVID_FRAME_BYTES),
    .CsInactiveClks (`SPI_CS_INACTIVE_CLKS)
  ) spiCsFrame_inst (
    .i_Clk          (i_Clk),
    .i_Rst_L        (i_Rst_L),
    .i_TX_DV        (wTxDv),
    .i_Master_Ready (wMasterReady),
    .o_TX_Ready     (wTxReady),
    .o_Frame_Done   (wFrameDone),
    .o_SPI_CS_n     (o_SPI_CS_n)
  );

endmodule : devIdReader

`default_nettype wire

/* tests/clkGen.sv */
`default_nettype none

module clkGen
  #(parameter int HalfPeriod = 4,   // ns, 8 ns period
    parameter int RstCycles  = 4)   // Clock cycles with reset low
  (
    output logic o_Clk,
    output logic o_Rst_L
  );

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    o_Clk = 1'b0;
    forever #(HalfPeriod) o_Clk = ~o_Clk;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial
  begin
    o_Rst_L = 1'b0;
    repeat (RstCycles) @(posedge o_Clk);
    @(negedge o_Clk);
    o_Rst_L = 1'b1;
  end

endmodule : clkGen

`default_nettype wire

/* tests/spiSlaveModel.sv */
`default_nettype none

// Mode 0 peripheral, pins seen through i_Clk edge detection
module spiSlaveModel
  (
    input  wire logic             i_Clk,
    input  wire logic             i_Rst_L,
    input  wire logic             i_SPI_Clk,
    input  wire logic             i_SPI_MOSI,
    input  wire logic             i_SPI_CS_n,
    input  wire spiPkg::spiByte_t i_Id_Byte,     // Returned as third byte
    output logic                  o_SPI_MISO,
    output int                    o_Frame_Cnt,   // CS falling edges seen
    output int                    o_Byte_Cnt,    // MOSI bytes in latest frame
    output int                    o_Cs_Gap,      // CS high cycles before latest frame
    output spiPkg::spiByte_t      o_Mosi_Byte0,
    output spiPkg::spiByte_t      o_Mosi_Byte1,
    output spiPkg::spiByte_t      o_Mosi_Byte2
  );

  timeunit 1ns;
  timeprecision 100ps;

  import spiPkg::*;

  logic     prevClk;
  logic     prevCs;
  int       txBit;     // Next MISO bit in the frame
  int       rxBits;    // MOSI bits in the current byte
  int       highCnt;   // Cycles CS has been high
  spiByte_t rxShift;

  // Frame reply, first two bytes are don't-care filler
  function automatic logic misoBit(input int n, input spiByte_t id);
    spiByte_t b;
    case (n / 8)
      0:       b = 8'h5A;
      1:       b = 8'hC3;
      2:       b = id;
      default: b = 8'h00;
    endcase
    return b[7 - (n % 8)];   // MSB first
  endfunction

  //////////////////////////////
  // Pin activity
  //////////////////////////////
  always @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      prevClk      <= 1'b0;
      prevCs       <= 1'b1;
      txBit        <= 0;
      rxBits       <= 0;
      highCnt      <= 0;
      rxShift      <= '0;
      o_SPI_MISO   <= 1'b0;
      o_Frame_Cnt  <= 0;
      o_Byte_Cnt   <= 0;
      o_Cs_Gap     <= 0;
      o_Mosi_Byte0 <= '0;
      o_Mosi_Byte1 <= '0;
      o_Mosi_Byte2 <= '0;
    end
    else
    begin
      prevClk <= i_SPI_Clk;
      prevCs  <= i_SPI_CS_n;
      highCnt <= i_SPI_CS_n ? highCnt + 1 : 0;
      if (prevCs && !i_SPI_CS_n)                     // CS fell, frame opens
      begin
        o_Frame_Cnt <= o_Frame_Cnt + 1;
        o_Cs_Gap    <= highCnt;
        o_Byte_Cnt  <= 0;
        o_SPI_MISO  <= misoBit(0, i_Id_Byte);        // First bit before any edge
        txBit       <= 1;
        rxBits      <= 0;
      end
      else if (!i_SPI_CS_n)
      begin
        if (prevClk && !i_SPI_Clk)                   // SCLK fell, next bit out
        begin
          o_SPI_MISO <= misoBit(txBit, i_Id_Byte);
          txBit      <= txBit + 1;
        end
        if (!prevClk && i_SPI_Clk)                   // SCLK rose, take MOSI
        begin
          rxShift <= {rxShift[6:0], i_SPI_MOSI};
          if (rxBits == 7)
          begin
            case (o_Byte_Cnt)
              0:       o_Mosi_Byte0 <= {rxShift[6:0], i_SPI_MOSI};
              1:       o_Mosi_Byte1 <= {rxShift[6:0], i_SPI_MOSI};
              2:       o_Mosi_Byte2 <= {rxShift[6:0], i_SPI_MOSI};
              default: ;                             // Extra bytes only counted
            endcase
            o_Byte_Cnt <= o_Byte_Cnt + 1;
            rxBits     <= 0;
          end
          else
            rxBits <= rxBits + 1;
        end
      end
    end
  end

endmodule : spiSlaveModel

`default_nettype wire

/* tests/devIdReaderTb.sv */
`default_nettype none

`include "devId_consts.svh"

module devIdReaderTb;

  timeunit 1ns;
  timeprecision 100ps;

  import spiPkg::*;

  localparam int DoneTimeout  = 3000;   // Cycles, one read needs about 220
  localparam int BusyTimeout  = 20;
  localparam int ResetTimeout = 20;

  logic     i_Clk;
  logic     i_Rst_L;
  logic     i_Start;
  logic     wMiso;
  logic     o_SPI_Clk;
  logic     o_SPI_MOSI;
  logic     o_SPI_CS_n;
  logic     o_Busy;
  logic     o_Done;
  spiByte_t o_Id_Byte;
  logic     o_Id_Match;
  spiByte_t slaveId;    // Third byte the slave returns
  int       frameCnt;
  int       byteCnt;
  int       csGap;
  spiByte_t mosiByte0;
  spiByte_t mosiByte1;
  spiByte_t mosiByte2;
  int       errCnt;
  int       passCnt;
  int       failCnt;

  clkGen #(.HalfPeriod(4), .RstCycles(4)) clkGen_inst (
    .o_Clk   (i_Clk),
    .o_Rst_L (i_Rst_L)
  );

  devIdReader devIdReader_inst (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_Start    (i_Start),
    .i_SPI_MISO (wMiso),
    .o_SPI_Clk  (o_SPI_Clk),
    .o_SPI_MOSI (o_SPI_MOSI),
    .o_SPI_CS_n (o_SPI_CS_n),
    .o_Busy     (o_Busy),
    .o_Done     (o_Done),
    .o_Id_Byte  (o_Id_Byte),
    .o_Id_Match (o_Id_Match)
  );

  spiSlaveModel spiSlaveModel_inst (
    .i_Clk        (i_Clk),
    .i_Rst_L      (i_Rst_L),
    .i_SPI_Clk    (o_SPI_Clk),
    .i_SPI_MOSI   (o_SPI_MOSI),
    .i_SPI_CS_n   (o_SPI_CS_n),
    .i_Id_Byte    (slaveId),
    .o_SPI_MISO   (wMiso),
    .o_Frame_Cnt  (frameCnt),
    .o_Byte_Cnt   (byteCnt),
    .o_Cs_Gap     (csGap),
    .o_Mosi_Byte0 (mosiByte0),
    .o_Mosi_Byte1 (mosiByte1),
    .o_Mosi_Byte2 (mosiByte2)
  );

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic compareByte(input spiByte_t act, input spiByte_t exp, input string what);
    if (act !== exp)
    begin
      errCnt++;
      $display("[ERROR] %0d ns: %s is 0x%02h, expected 0x%02h", $time, what, act, exp);
    end
  endtask

  task automatic compareFlag(input logic act, input logic exp, input string what);
    if (act !== exp)
    begin
      errCnt++;
      $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  task automatic compareCount(input int act, input int exp, input string what);
    if (act != exp)
    begin
      errCnt++;
      $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, act, exp);
    end
  endtask

  // Byte as the slave sent it, match flag as the test expects it
  task automatic checkResult(input spiByte_t id, input logic expMatch, input string tag);
    compareByte(o_Id_Byte, id, {tag, " o_Id_Byte"});
    compareFlag(o_Id_Match, expMatch, {tag, " o_Id_Match"});
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    if (errCnt == errsBefore)
    begin
      passCnt++;
      $display("PASS  %s", name);
    end
    else
    begin
      failCnt++;
      $display("FAIL  %s (%0d errors)", name, errCnt - errsBefore);
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  // Start held until the sequencer leaves idle
  task automatic launchRead(input spiByte_t id);
    int cyc;
    @(negedge i_Clk);
    slaveId = id;
    i_Start = 1'b1;
    for (cyc = 0; cyc < BusyTimeout && !o_Busy; cyc++)
      @(negedge i_Clk);
    if (!o_Busy)
    begin
      errCnt++;
      $display("Timeout: o_Busy did not rise within %0d cycles of i_Start", BusyTimeout);
    end
    i_Start = 1'b0;
  endtask

  // Returns on the falling edge inside the o_Done cycle
  task automatic waitDone(output bit seen);
    int cyc;
    seen = 1'b0;
    for (cyc = 0; cyc < DoneTimeout; cyc++)
    begin
      @(negedge i_Clk);
      if (o_Done)
      begin
        seen = 1'b1;
        break;
      end
    end
    if (!seen)
    begin
      errCnt++;
      $display("Timeout: o_Done did not pulse within %0d cycles", DoneTimeout);
    end
  endtask

  task automatic runRead(input spiByte_t id, output bit seen);
    launchRead(id);
    waitDone(seen);
  endtask

  function automatic spiByte_t randomWrongId();
    spiByte_t id;
    id = spiByte_t'($urandom);
    while (id == `DEVID_EXPECTED)
      id = spiByte_t'($urandom);
    return id;
  endfunction

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic testReset();
    int errsBefore;
    errsBefore = errCnt;
    compareFlag(o_SPI_CS_n, 1'b1, "CS_n after reset");
    compareFlag(o_SPI_Clk, 1'b0, "SCLK after reset");   // Mode 0 idle low
    compareFlag(o_Busy, 1'b0, "o_Busy after reset");
    compareFlag(o_Done, 1'b0, "o_Done after reset");
    compareByte(o_Id_Byte, 8'h00, "o_Id_Byte after reset");
    compareFlag(o_Id_Match, 1'b0, "o_Id_Match after reset");
    reportTest("reset state", errsBefore);
  endtask

  task automatic testMatchingId();
    int errsBefore;
    bit seen;
    errsBefore = errCnt;
    runRead(`DEVID_EXPECTED, seen);
    if (seen)
      checkResult(8'hAD, 1'b1, "matching read");
    reportTest("matching ID", errsBefore);
  endtask

  task automatic testMismatchId();
    int errsBefore;
    bit seen;
    spiByte_t id;
    errsBefore = errCnt;
    id = randomWrongId();
    runRead(id, seen);
    if (seen)
      checkResult(id, 1'b0, "mismatching read");
    reportTest($sformatf("mismatching ID 0x%02h", id), errsBefore);
  endtask

  task automatic testMosiBytes();
    int errsBefore;
    int framesBefore;
    bit seen;
    errsBefore   = errCnt;
    framesBefore = frameCnt;
    runRead(spiByte_t'($urandom), seen);
    if (seen)
    begin
      compareCount(frameCnt - framesBefore, 1, "CS frames per read");
      compareCount(byteCnt, `DEVID_FRAME_BYTES, "MOSI bytes in the frame");
      compareByte(mosiByte0, `DEVID_READ_CMD, "MOSI byte 0");
      compareByte(mosiByte1, `DEVID_REG_ADDR, "MOSI byte 1");
      compareByte(mosiByte2, 8'h00, "MOSI byte 2");       // Dummy
    end
    reportTest("bytes on MOSI", errsBefore);
  endtask

  task automatic testIdleNoStart();
    int errsBefore;
    int framesBefore;
    int cyc;
    errsBefore   = errCnt;
    framesBefore = frameCnt;
    i_Start      = 1'b0;
    for (cyc = 0; cyc < 200; cyc++)
    begin
      @(negedge i_Clk);
      if (o_SPI_CS_n !== 1'b1 || o_Done !== 1'b0)
      begin
        compareFlag(o_SPI_CS_n, 1'b1, "CS_n while idle");
        compareFlag(o_Done, 1'b0, "o_Done while idle");
        break;                                            // Stop at the first bad cycle
      end
    end
    compareCount(frameCnt - framesBefore, 0, "CS frames without start");
    reportTest("idle without start", errsBefore);
  endtask

  task automatic testBackToBack();
    int errsBefore;
    int framesBefore;
    bit seen;
    spiByte_t id1;
    errsBefore   = errCnt;
    framesBefore = frameCnt;
    id1          = randomWrongId();
    @(negedge i_Clk);
    slaveId = id1;
    i_Start = 1'b1;                                       // Held across both reads
    waitDone(seen);
    if (seen)
    begin
      checkResult(id1, 1'b0, "first read");
      slaveId = `DEVID_EXPECTED;                          // Second frame not yet open
      waitDone(seen);
    end
    i_Start = 1'b0;                                       // Before idle samples it again
    if (seen)
    begin
      checkResult(8'hAD, 1'b1, "second read");
      compareCount(frameCnt - framesBefore, 2, "CS frames in two reads");
      compareFlag(csGap >= `SPI_CS_INACTIVE_CLKS + 1, 1'b1,
                  $sformatf("CS gap of %0d cycles long enough", csGap));
    end
    reportTest("back-to-back reads", errsBefore);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    int cyc;
    void'($urandom(43));
    i_Start = 1'b0;
    slaveId = 8'h00;
    errCnt  = 0;
    passCnt = 0;
    failCnt = 0;

    for (cyc = 0; cyc < ResetTimeout && i_Rst_L !== 1'b1; cyc++)
      @(negedge i_Clk);
    if (i_Rst_L !== 1'b1)
    begin
      errCnt++;
      $display("Reset was not released within %0d cycles", ResetTimeout);
    end
    @(negedge i_Clk);

    testReset();
    testMatchingId();
    testMismatchId();
    testMosiBytes();
    testIdleNoStart();
    testBackToBack();

    $display("Tests passed: %0d, failed: %0d, errors: %0d", passCnt, failCnt, errCnt);
    if (errCnt == 0 && failCnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule : devIdReaderTb

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/spiPkg.sv
hdl/devIdPkg.sv
hdl/spiByteMaster.sv
hdl/spiCsFrame.sv
hdl/devIdSequencer.sv
hdl/devIdReader.sv
tests/clkGen.sv
tests/spiSlaveModel.sv
tests/devIdReaderTb.sv

/* run.sh */
#!/bin/sh
# Build and run the devIdReader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f files.f --top-module devIdReaderTb --Mdir obj_dir -o devIdReaderSim

./obj_dir/devIdReaderSim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
